//--- Bender.yml
package:
  name: mips_core

sources:
  - mips_pkg.sv
  - instr_latch.sv
  - control_unit.sv
  - register_file.sv
  - exec_stage.sv
  - mem_writeback.sv
  - mips_core.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_mips_core.sv

//--- control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit (
    input  wire logic [mips_pkg::NB-1:0]      i_instruction,
    output logic                              o_alu_src,
    output mips_pkg::alu_op_e                 o_alu_op,
    output mips_pkg::ext_mode_e               o_ext_mode,
    output logic                              o_mem_read,
    output logic                              o_mem_write,
    output logic                              o_reg_write,
    output logic      [mips_pkg::NB_REGS-1:0] o_reg_dir_to_write,
    output logic                              o_branch,
    output logic                              o_jump,
    output mips_pkg::word_size_e              o_word_size
);
    import mips_pkg::*;

    opcode_e            opcode;
    funct_e             funct;
    logic [NB_REGS-1:0] rt;
    logic [NB_REGS-1:0] rd;

    assign opcode = opcode_e'(i_instruction[31:26]);
    assign funct  = funct_e'(i_instruction[5:0]);
    assign rt     = i_instruction[20:16];
    assign rd     = i_instruction[15:11];

    always_comb begin
        // Defaults decode as no operation
        o_alu_src          = 1'b0;
        o_alu_op           = ALU_ADD;
        o_ext_mode         = EXT_SIGNED;
        o_mem_read         = 1'b0;
        o_mem_write        = 1'b0;
        o_reg_write        = 1'b0;
        o_reg_dir_to_write = '0;
        o_branch           = 1'b0;
        o_jump             = 1'b0;
        o_word_size        = SIZE_WORD;

        case (opcode)
            OP_RTYPE: begin
                o_reg_dir_to_write = rd;
                o_reg_write        = 1'b1;
                case (funct)
                    FN_ADD:  o_alu_op = ALU_ADD;
                    FN_SUB:  o_alu_op = ALU_SUB;
                    FN_AND:  o_alu_op = ALU_AND;
                    FN_OR:   o_alu_op = ALU_OR;
                    FN_SLT:  o_alu_op = ALU_SLT;
                    default: o_reg_write = 1'b0;  // Unknown function
                endcase
            end
            OP_ADDI: begin
                o_alu_src          = 1'b1;
                o_reg_write        = 1'b1;
                o_reg_dir_to_write = rt;
            end
            OP_ANDI: begin
                o_alu_src          = 1'b1;
                o_alu_op           = ALU_AND;
                o_ext_mode         = EXT_UNSIGNED;
                o_reg_write        = 1'b1;
                o_reg_dir_to_write = rt;
            end
            OP_LB, OP_LH, OP_LW: begin
                o_alu_src          = 1'b1;  // Base plus offset
                o_mem_read         = 1'b1;
                o_reg_write        = 1'b1;
                o_reg_dir_to_write = rt;
                o_word_size        = (opcode == OP_LB) ? SIZE_BYTE :
                                     (opcode == OP_LH) ? SIZE_HALF : SIZE_WORD;
            end
            OP_SB, OP_SH, OP_SW: begin
                o_alu_src   = 1'b1;
                o_mem_write = 1'b1;
                o_word_size = (opcode == OP_SB) ? SIZE_BYTE :
                              (opcode == OP_SH) ? SIZE_HALF : SIZE_WORD;
            end
            OP_BEQ:  o_branch = 1'b1;
            OP_J:    o_jump   = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        a_rd_wr_excl: assert final (!(o_mem_read && o_mem_write));
    end

endmodule

`default_nettype wire

//--- exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exec_stage (
    input  wire logic                         i_clk,
    input  wire logic                         i_rst_n,
    input  wire logic                         i_valid,
    input  wire logic [mips_pkg::NB-1:0]      i_instr,
    input  wire logic [mips_pkg::NB-1:0]      i_pc,
    input  wire logic [mips_pkg::NB-1:0]      i_rs_data,
    input  wire logic [mips_pkg::NB-1:0]      i_rt_data,
    input  wire logic                         i_alu_src,
    input  wire mips_pkg::alu_op_e            i_alu_op,
    input  wire mips_pkg::ext_mode_e          i_ext_mode,
    input  wire logic                         i_mem_read,
    input  wire logic                         i_mem_write,
    input  wire logic                         i_reg_write,
    input  wire logic [mips_pkg::NB_REGS-1:0] i_dest,
    input  wire logic                         i_branch,
    input  wire logic                         i_jump,
    input  wire mips_pkg::word_size_e         i_word_size,
    output logic                              o_valid,
    output logic      [mips_pkg::NB-1:0]      o_alu_result,
    output logic      [mips_pkg::NB-1:0]      o_store_data,
    output logic                              o_mem_read,
    output logic                              o_mem_write,
    output mips_pkg::word_size_e              o_word_size,
    output logic                              o_reg_write,
    output logic      [mips_pkg::NB_REGS-1:0] o_dest,
    output logic                              o_redirect,
    output logic      [mips_pkg::NB-1:0]      o_redirect_pc
);
    import mips_pkg::*;

    logic [NB-1:0] ext_imm;
    logic [NB-1:0] operand_b;
    logic [NB-1:0] alu_result;
    logic [NB-1:0] pc_plus4;
    logic [NB-1:0] target;
    logic          take_branch;

    assign ext_imm     = (i_ext_mode == EXT_SIGNED) ? {{16{i_instr[15]}}, i_instr[15:0]}
                                                    : {16'b0, i_instr[15:0]};
    assign operand_b   = i_alu_src ? ext_imm : i_rt_data;
    assign pc_plus4    = i_pc + NB'(4);
    assign take_branch = i_branch && (i_rs_data == i_rt_data);

    // J keeps the top nibble of pc+4
    assign target = i_jump ? {pc_plus4[NB-1:NB-4], i_instr[25:0], 2'b00}
                           : pc_plus4 + {ext_imm[NB-3:0], 2'b00};

    always_comb begin
        case (i_alu_op)
            ALU_ADD: alu_result = i_rs_data + operand_b;
            ALU_SUB: alu_result = i_rs_data - operand_b;
            ALU_AND: alu_result = i_rs_data & operand_b;
            ALU_OR:  alu_result = i_rs_data | operand_b;
            ALU_SLT: alu_result = {{(NB-1){1'b0}}, $signed(i_rs_data) < $signed(operand_b)};
            default: alu_result = '0;
        endcase
    end

    ///////////////////////////////////////////////////////////////////////
    // Stage register

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid     <= 1'b0;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
            o_reg_write <= 1'b0;
            o_redirect  <= 1'b0;
        end else begin
            o_valid     <= i_valid;
            o_mem_read  <= i_valid && i_mem_read;
            o_mem_write <= i_valid && i_mem_write;
            o_reg_write <= i_valid && i_reg_write;
            o_redirect  <= i_valid && (take_branch || i_jump);
        end
    end

    always_ff @(posedge i_clk) begin
        o_alu_result  <= i_valid ? alu_result  : '0;
        o_store_data  <= i_valid ? i_rt_data   : '0;
        o_word_size   <= i_valid ? i_word_size : SIZE_WORD;
        o_dest        <= i_valid ? i_dest      : '0;
        o_redirect_pc <= target;  // Only meaningful with o_redirect
    end

endmodule

`default_nettype wire

//--- instr_latch.sv
`timescale 1ns/10ps
`default_nettype none

module instr_latch (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_instr_valid,
    input  wire logic [mips_pkg::NB-1:0] i_instr,
    input  wire logic                    i_redirect,
    input  wire logic [mips_pkg::NB-1:0] i_redirect_pc,
    output logic                         o_valid,
    output logic      [mips_pkg::NB-1:0] o_instr,
    output logic      [mips_pkg::NB-1:0] o_pc
);
    import mips_pkg::*;

    logic [NB-1:0] pc;  // PC given to the next strobe

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            pc      <= '0;
        end else begin
            o_valid <= i_instr_valid;
            if (i_redirect)
                pc <= i_redirect_pc;  // Wins over the +4 of a strobe in the same cycle
            else if (i_instr_valid)
                pc <= pc + NB'(4);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_instr_valid) begin
            o_instr <= i_instr;
            o_pc    <= pc;
        end
    end

    // Targets from the exec stage are always word aligned
    a_redirect_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_redirect |-> (i_redirect_pc[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- mem_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module mem_writeback #(
    parameter int unsigned DMEM_WORDS = 64
) (
    input  wire logic                         i_clk,
    input  wire logic                         i_rst_n,
    input  wire logic                         i_valid,
    input  wire logic [mips_pkg::NB-1:0]      i_alu_result,
    input  wire logic [mips_pkg::NB-1:0]      i_store_data,
    input  wire logic                         i_mem_read,
    input  wire logic                         i_mem_write,
    input  wire mips_pkg::word_size_e         i_word_size,
    input  wire logic                         i_reg_write,
    input  wire logic [mips_pkg::NB_REGS-1:0] i_dest,
    output logic                              o_rf_we,
    output logic      [mips_pkg::NB_REGS-1:0] o_rf_waddr,
    output logic      [mips_pkg::NB-1:0]      o_rf_wdata,
    output logic                              o_wb_valid,
    output logic      [mips_pkg::NB_REGS-1:0] o_wb_reg,
    output logic      [mips_pkg::NB-1:0]      o_wb_data,
    output logic                              o_store_valid,
    output logic      [mips_pkg::NB-1:0]      o_store_addr,
    output logic      [mips_pkg::NB-1:0]      o_store_data,
    output mips_pkg::word_size_e              o_store_size
);
    import mips_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    logic [NB-1:0] dmem [DMEM_WORDS];
    logic [AW-1:0] word_idx;
    logic [NB-1:0] rd_word;
    logic [7:0]    ld_byte;
    logic [15:0]   ld_half;
    logic [NB-1:0] load_data;
    logic [3:0]    byte_en;
    logic [NB-1:0] st_word;    // Store data on its lanes
    logic [NB-1:0] st_report;  // Store data, zero above its size

    assign word_idx = AW'(i_alu_result[NB-1:2] % DMEM_WORDS);
    assign rd_word  = dmem[word_idx];
    assign ld_byte  = rd_word[{i_alu_result[1:0], 3'b000} +: 8];
    assign ld_half  = rd_word[{i_alu_result[1], 4'b0000} +: 16];

    always_comb begin
        case (i_word_size)
            SIZE_BYTE: begin
                load_data = {{24{ld_byte[7]}}, ld_byte};
                byte_en   = 4'b0001 << i_alu_result[1:0];
                st_word   = {4{i_store_data[7:0]}};
                st_report = {24'b0, i_store_data[7:0]};
            end
            SIZE_HALF: begin
                load_data = {{16{ld_half[15]}}, ld_half};
                byte_en   = i_alu_result[1] ? 4'b1100 : 4'b0011;
                st_word   = {2{i_store_data[15:0]}};
                st_report = {16'b0, i_store_data[15:0]};
            end
            default: begin
                load_data = rd_word;
                byte_en   = 4'b1111;
                st_word   = i_store_data;
                st_report = i_store_data;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int w = 0; w < DMEM_WORDS; w++) begin
                dmem[w] <= '0;
            end
        end else if (i_valid && i_mem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b])
                    dmem[word_idx][8*b +: 8] <= st_word[8*b +: 8];
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Register file write port and reports

    assign o_rf_we    = i_valid && i_reg_write;
    assign o_rf_waddr = i_dest;
    assign o_rf_wdata = i_mem_read ? load_data : i_alu_result;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_wb_valid    <= 1'b0;
            o_store_valid <= 1'b0;
        end else begin
            o_wb_valid    <= o_rf_we;
            o_store_valid <= i_valid && i_mem_write;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_reg     <= i_dest;
        o_wb_data    <= (i_dest == '0) ? '0 : o_rf_wdata;  // r0 reads back as zero
        o_store_addr <= i_alu_result;
        o_store_data <= st_report;
        o_store_size <= i_word_size;
    end

    a_half_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid && (i_mem_read || i_mem_write) && (i_word_size == SIZE_HALF)
        |-> !i_alu_result[0]);

    a_word_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid && (i_mem_read || i_mem_write) && (i_word_size == SIZE_WORD)
        |-> (i_alu_result[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module mips_core #(
    parameter int unsigned DMEM_WORDS = 64
) (
    input  wire logic                         i_clk,
    input  wire logic                         i_rst_n,
    input  wire logic                         i_instr_valid,
    input  wire logic [mips_pkg::NB-1:0]      i_instr,
    output logic                              o_wb_valid,
    output logic      [mips_pkg::NB_REGS-1:0] o_wb_reg,
    output logic      [mips_pkg::NB-1:0]      o_wb_data,
    output logic                              o_store_valid,
    output logic      [mips_pkg::NB-1:0]      o_store_addr,
    output logic      [mips_pkg::NB-1:0]      o_store_data,
    output mips_pkg::word_size_e              o_store_size,
    output logic                              o_redirect,
    output logic      [mips_pkg::NB-1:0]      o_redirect_pc
);
    import mips_pkg::*;

    // Stage 1
    logic               s1_valid;
    logic [NB-1:0]      s1_instr;
    logic [NB-1:0]      s1_pc;
    logic [NB-1:0]      rs_data;
    logic [NB-1:0]      rt_data;
    logic               ctl_alu_src;
    alu_op_e            ctl_alu_op;
    ext_mode_e          ctl_ext_mode;
    logic               ctl_mem_read;
    logic               ctl_mem_write;
    logic               ctl_reg_write;
    logic [NB_REGS-1:0] ctl_dest;
    logic               ctl_branch;
    logic               ctl_jump;
    word_size_e         ctl_word_size;

    // Stage 2
    logic               s2_valid;
    logic [NB-1:0]      s2_alu_result;
    logic [NB-1:0]      s2_store_data;
    logic               s2_mem_read;
    logic               s2_mem_write;
    word_size_e         s2_word_size;
    logic               s2_reg_write;
    logic [NB_REGS-1:0] s2_dest;

    logic               wb_we;
    logic [NB_REGS-1:0] wb_addr;
    logic [NB-1:0]      wb_data;

    instr_latch u_instr_latch (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_redirect    (o_redirect),
        .i_redirect_pc (o_redirect_pc),
        .o_valid       (s1_valid),
        .o_instr       (s1_instr),
        .o_pc          (s1_pc)
    );

    control_unit u_control_unit (
        .i_instruction      (s1_instr),
        .o_alu_src          (ctl_alu_src),
        .o_alu_op           (ctl_alu_op),
        .o_ext_mode         (ctl_ext_mode),
        .o_mem_read         (ctl_mem_read),
        .o_mem_write        (ctl_mem_write),
        .o_reg_write        (ctl_reg_write),
        .o_reg_dir_to_write (ctl_dest),
        .o_branch           (ctl_branch),
        .o_jump             (ctl_jump),
        .o_word_size        (ctl_word_size)
    );

    register_file u_register_file (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rs      (s1_instr[25:21]),
        .i_rt      (s1_instr[20:16]),
        .i_we      (wb_we),
        .i_waddr   (wb_addr),
        .i_wdata   (wb_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    exec_stage u_exec_stage (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (s1_valid),
        .i_instr       (s1_instr),
        .i_pc          (s1_pc),
        .i_rs_data     (rs_data),
        .i_rt_data     (rt_data),
        .i_alu_src     (ctl_alu_src),
        .i_alu_op      (ctl_alu_op),
        .i_ext_mode    (ctl_ext_mode),
        .i_mem_read    (ctl_mem_read),
        .i_mem_write   (ctl_mem_write),
        .i_reg_write   (ctl_reg_write),
        .i_dest        (ctl_dest),
        .i_branch      (ctl_branch),
        .i_jump        (ctl_jump),
        .i_word_size   (ctl_word_size),
        .o_valid       (s2_valid),
        .o_alu_result  (s2_alu_result),
        .o_store_data  (s2_store_data),
        .o_mem_read    (s2_mem_read),
        .o_mem_write   (s2_mem_write),
        .o_word_size   (s2_word_size),
        .o_reg_write   (s2_reg_write),
        .o_dest        (s2_dest),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

    mem_writeback #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_mem_writeback (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (s2_valid),
        .i_alu_result  (s2_alu_result),
        .i_store_data  (s2_store_data),
        .i_mem_read    (s2_mem_read),
        .i_mem_write   (s2_mem_write),
        .i_word_size   (s2_word_size),
        .i_reg_write   (s2_reg_write),
        .i_dest        (s2_dest),
        .o_rf_we       (wb_we),
        .o_rf_waddr    (wb_addr),
        .o_rf_wdata    (wb_data),
        .o_wb_valid    (o_wb_valid),
        .o_wb_reg      (o_wb_reg),
        .o_wb_data     (o_wb_data),
        .o_store_valid (o_store_valid),
        .o_store_addr  (o_store_addr),
        .o_store_data  (o_store_data),
        .o_store_size  (o_store_size)
    );

endmodule

`default_nettype wire

//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int NB        = 32;  // Data and instruction width
    localparam int NB_REGS   = 5;
    localparam int NB_OPCODE = 6;   // Also the function field width

    typedef enum logic [NB_OPCODE-1:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_ADDI  = 6'b001000,
        OP_ANDI  = 6'b001100,
        OP_LB    = 6'b100000,
        OP_LH    = 6'b100001,
        OP_LW    = 6'b100011,
        OP_SB    = 6'b101000,
        OP_SH    = 6'b101001,
        OP_SW    = 6'b101011
    } opcode_e;

    // R-type function field
    typedef enum logic [NB_OPCODE-1:0] {
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_SLT = 6'b101010
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic {
        EXT_SIGNED,
        EXT_UNSIGNED
    } ext_mode_e;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } word_size_e;

endpackage

`default_nettype wire

//--- register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  wire logic                         i_clk,
    input  wire logic                         i_rst_n,
    input  wire logic [mips_pkg::NB_REGS-1:0] i_rs,
    input  wire logic [mips_pkg::NB_REGS-1:0] i_rt,
    input  wire logic                         i_we,
    input  wire logic [mips_pkg::NB_REGS-1:0] i_waddr,
    input  wire logic [mips_pkg::NB-1:0]      i_wdata,
    output logic      [mips_pkg::NB-1:0]      o_rs_data,
    output logic      [mips_pkg::NB-1:0]      o_rt_data
);
    import mips_pkg::*;

    logic [NB-1:0] regs [2**NB_REGS];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int r = 0; r < 2**NB_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Read ports, bypassing the write in flight

    assign o_rs_data = (i_rs == '0)                   ? '0      :
                       (i_we && (i_waddr == i_rs))    ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_rt == '0)                   ? '0      :
                       (i_we && (i_waddr == i_rt))    ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 16
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;  // Released on an edge, sampled at the next
    end

endmodule

`default_nettype wire

//--- tb_mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core;
    import mips_pkg::*;

    localparam int CLK_PERIOD_NS = 20;
    localparam int RST_CYCLES    = 16;
    localparam int DMEM_WORDS    = 64;
    localparam int N_INSTR       = 400;
    localparam int IDLE_CYCLES   = 10;  // Quiet time after reset
    localparam int NUM_REGS      = 6;   // r0..r5 only
    localparam int TIMEOUT_NS    = (N_INSTR * 4 + RST_CYCLES) * CLK_PERIOD_NS;

    logic               clk;
    logic               rst_n;
    logic               instr_valid;
    logic [NB-1:0]      instr;
    logic               wb_valid;
    logic [NB_REGS-1:0] wb_reg;
    logic [NB-1:0]      wb_data;
    logic               store_valid;
    logic [NB-1:0]      store_addr;
    logic [NB-1:0]      store_data;
    word_size_e         store_size;
    logic               redirect;
    logic [NB-1:0]      redirect_pc;

    // Reference model state
    logic [NB-1:0] regs_model [32];
    logic [NB-1:0] mem_model [DMEM_WORDS];
    logic [NB-1:0] model_pc;
    logic [NB-1:0] lcg_state = 32'hb60c_5fa6;

    // Expected outputs, one slot per cycle, modulo 8
    logic          exp_wb_v    [8];
    logic [4:0]    exp_wb_reg  [8];
    logic [NB-1:0] exp_wb_data [8];
    logic          exp_st_v    [8];
    logic [NB-1:0] exp_st_addr [8];
    logic [NB-1:0] exp_st_data [8];
    logic [1:0]    exp_st_size [8];
    logic          exp_rd_v    [8];
    logic [NB-1:0] exp_rd_pc   [8];

    int unsigned errors;
    int unsigned checks;

    tb_clock_gen #(
        .PERIOD_NS  (CLK_PERIOD_NS),
        .RST_CYCLES (RST_CYCLES)
    ) i_clock_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    mips_core #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_dut (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .o_wb_valid    (wb_valid),
        .o_wb_reg      (wb_reg),
        .o_wb_data     (wb_data),
        .o_store_valid (store_valid),
        .o_store_addr  (store_addr),
        .o_store_data  (store_data),
        .o_store_size  (store_size),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    //////////////////////////////////////////////////////////////////////
    // Random numbers and instruction generation

    function automatic logic [NB-1:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        logic [NB-1:0] r;
        r = lcg_next();
        return (r >> 16) % n;  // Upper bits are the better ones
    endfunction

    function automatic logic [NB-1:0] gen_instr();
        logic [NB-1:0] r;
        logic [4:0]    rs;
        logic [4:0]    rt;
        logic [4:0]    rd;
        logic [5:0]    fn;
        logic [5:0]    op;
        logic [15:0]   offs;
        int unsigned   kind;
        int unsigned   sel;
        int unsigned   word;
        r    = lcg_next();
        rs   = 5'(rand_below(NUM_REGS));
        rt   = 5'(rand_below(NUM_REGS));
        rd   = 5'(rand_below(NUM_REGS));
        kind = rand_below(16);
        sel  = rand_below(6);
        // Half the accesses hit the first four words so loads meet stores
        word = (rand_below(2) == 0) ? rand_below(4) : rand_below(DMEM_WORDS);
        offs = 16'(word * 4 + rand_below(4));
        case (sel)
            0:       fn = FN_ADD;
            1:       fn = FN_SUB;
            2:       fn = FN_AND;
            3:       fn = FN_OR;
            4:       fn = FN_SLT;
            default: fn = 6'b000000;  // Unknown function
        endcase
        sel = sel % 3;  // Access size
        if (sel == 1)
            offs[0] = 1'b0;
        if (sel == 2)
            offs[1:0] = 2'b00;
        case (kind)
            0, 1, 2, 3: return {OP_RTYPE, rs, rt, rd, 5'b00000, fn};
            4, 5, 6, 15: return {OP_ADDI, rs, rt, r[31:16]};
            7: return {OP_ANDI, rs, rt, r[31:16]};
            8, 9: begin
                op = (sel == 0) ? OP_LB : (sel == 1) ? OP_LH : OP_LW;
                return {op, 5'd0, rt, offs};
            end
            10, 11: begin
                op = (sel == 0) ? OP_SB : (sel == 1) ? OP_SH : OP_SW;
                return {op, 5'd0, rt, offs};
            end
            12: return {OP_BEQ, rs, (r[24] ? rs : rt), r[23:8]};
            13: return {OP_J, r[31:6]};
            default: return {(r[5] ? 6'b111111 : 6'b010000), r[31:6]};
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Model and checks

    task automatic clear_slot(input int unsigned s);
        exp_wb_v[s]    = 1'b0;
        exp_wb_reg[s]  = '0;
        exp_wb_data[s] = '0;
        exp_st_v[s]    = 1'b0;
        exp_st_addr[s] = '0;
        exp_st_data[s] = '0;
        exp_st_size[s] = '0;
        exp_rd_v[s]    = 1'b0;
        exp_rd_pc[s]   = '0;
    endtask

    task automatic model_step(input logic [NB-1:0] ins, input int unsigned cyc);
        logic [5:0]    op;
        logic [4:0]    rs;
        logic [4:0]    rt;
        logic [4:0]    dest;
        logic [NB-1:0] a;
        logic [NB-1:0] b;
        logic [NB-1:0] simm;
        logic [NB-1:0] addr;
        logic [NB-1:0] pc4;
        logic [NB-1:0] lane;
        logic [NB-1:0] mask;
        logic [NB-1:0] result;
        logic [4:0]    sh;
        logic          wr;
        int unsigned   widx;
        int unsigned   s_wb;
        int unsigned   s_rd;
        op     = ins[31:26];
        rs     = ins[25:21];
        rt     = ins[20:16];
        dest   = rt;
        a      = regs_model[rs];
        b      = regs_model[rt];
        simm   = {{16{ins[15]}}, ins[15:0]};
        addr   = a + simm;
        widx   = (addr >> 2) % DMEM_WORDS;
        sh     = {addr[1:0], 3'b000};
        lane   = mem_model[widx] >> sh;
        pc4    = model_pc + 32'd4;
        wr     = 1'b1;
        result = '0;
        s_wb   = (cyc + 3) % 8;
        s_rd   = (cyc + 2) % 8;
        case (op)
            OP_RTYPE: begin
                dest = ins[15:11];
                case (ins[5:0])
                    FN_ADD:  result = a + b;
                    FN_SUB:  result = a - b;
                    FN_AND:  result = a & b;
                    FN_OR:   result = a | b;
                    FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDI: result = a + simm;
            OP_ANDI: result = a & {16'b0, ins[15:0]};
            OP_LB:   result = {{24{lane[7]}}, lane[7:0]};
            OP_LH:   result = {{16{lane[15]}}, lane[15:0]};
            OP_LW:   result = lane;
            OP_SB, OP_SH, OP_SW: begin
                wr   = 1'b0;
                mask = (op == OP_SB) ? 32'h0000_00ff :
                       (op == OP_SH) ? 32'h0000_ffff : 32'hffff_ffff;
                mem_model[widx]   = (mem_model[widx] & ~(mask << sh)) | ((b & mask) << sh);
                exp_st_v[s_wb]    = 1'b1;
                exp_st_addr[s_wb] = addr;
                exp_st_data[s_wb] = b & mask;
                exp_st_size[s_wb] = (op == OP_SB) ? SIZE_BYTE :
                                    (op == OP_SH) ? SIZE_HALF : SIZE_WORD;
            end
            OP_BEQ: begin
                wr = 1'b0;
                if (a == b) begin
                    exp_rd_v[s_rd]  = 1'b1;
                    exp_rd_pc[s_rd] = pc4 + (simm << 2);
                end
            end
            OP_J: begin
                wr              = 1'b0;
                exp_rd_v[s_rd]  = 1'b1;
                exp_rd_pc[s_rd] = {pc4[31:28], ins[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr) begin
            if (dest != 5'd0)
                regs_model[dest] = result;
            exp_wb_v[s_wb]    = 1'b1;
            exp_wb_reg[s_wb]  = dest;
            exp_wb_data[s_wb] = (dest == 5'd0) ? '0 : result;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [NB-1:0] exp,
                                   input logic [NB-1:0] act);
        errors++;
        $display("error %s: expected %h, actual %h at %0t ns", name, exp, act, $time);
    endtask

    task automatic check_outputs(input int unsigned cyc);
        int unsigned s;
        s = cyc % 8;
        checks += 3;
        if (wb_valid !== exp_wb_v[s])
            report_mismatch("wb_valid", 32'(exp_wb_v[s]), 32'(wb_valid));
        if (store_valid !== exp_st_v[s])
            report_mismatch("store_valid", 32'(exp_st_v[s]), 32'(store_valid));
        if (redirect !== exp_rd_v[s])
            report_mismatch("redirect", 32'(exp_rd_v[s]), 32'(redirect));
        if (exp_wb_v[s] && wb_valid === 1'b1) begin
            checks += 2;
            if (wb_reg !== exp_wb_reg[s])
                report_mismatch("wb_reg", 32'(exp_wb_reg[s]), 32'(wb_reg));
            if (wb_data !== exp_wb_data[s])
                report_mismatch("wb_data", exp_wb_data[s], wb_data);
        end
        if (exp_st_v[s] && store_valid === 1'b1) begin
            checks += 3;
            if (store_addr !== exp_st_addr[s])
                report_mismatch("store_addr", exp_st_addr[s], store_addr);
            if (store_data !== exp_st_data[s])
                report_mismatch("store_data", exp_st_data[s], store_data);
            if (store_size !== exp_st_size[s])
                report_mismatch("store_size", 32'(exp_st_size[s]), 32'(store_size));
        end
        if (exp_rd_v[s] && redirect === 1'b1) begin
            checks++;
            if (redirect_pc !== exp_rd_pc[s])
                report_mismatch("redirect_pc", exp_rd_pc[s], redirect_pc);
        end
        clear_slot(s);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus, one pass per clock cycle

    initial begin : stimulus
        int unsigned   cyc;
        int unsigned   issued;
        int unsigned   gap;
        int unsigned   drain;
        logic          strobe;
        logic [NB-1:0] ins;
        instr_valid = 1'b0;
        instr       = '0;
        model_pc    = '0;
        errors      = 0;
        checks      = 0;
        for (int r = 0; r < 32; r++)
            regs_model[r] = '0;
        for (int w = 0; w < DMEM_WORDS; w++)
            mem_model[w] = '0;
        for (int k = 0; k < 8; k++)
            clear_slot(k);
        cyc    = 0;
        issued = 0;
        gap    = 0;
        drain  = 0;
        wait (rst_n === 1'b1);

        while (issued < N_INSTR || drain < 5) begin
            @(posedge clk);
            strobe = 1'b0;
            if (cyc >= IDLE_CYCLES && issued < N_INSTR) begin
                if (gap == 0) begin
                    strobe = 1'b1;
                    gap    = rand_below(3);
                end else begin
                    gap--;
                end
            end
            if (strobe) begin
                ins = gen_instr();
                model_step(ins, cyc);
                issued++;
            end else begin
                ins = lcg_next();  // Junk on the bus while idle
            end
            instr_valid <= strobe;
            instr       <= ins;
            // A redirect this cycle sets the PC for the next strobe
            if (exp_rd_v[cyc % 8])
                model_pc = exp_rd_pc[cyc % 8];
            else if (strobe)
                model_pc = model_pc + 32'd4;
            @(negedge clk);
            check_outputs(cyc);
            if (issued == N_INSTR)
                drain++;
            cyc++;
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
mips_pkg.sv
instr_latch.sv
control_unit.sv
register_file.sv
exec_stage.sv
mem_writeback.sv
mips_core.sv
tb_clock_gen.sv
tb_mips_core.sv
